// File: design/lsq_pkg.sv
// shared widths and packed bus types for the load-store queue, imported by every block
`default_nettype none

package lsq_pkg;

  localparam int XLEN    = 32;
  localparam int ROBID_W = 7;
  localparam int RD_W    = 5;
  // dcache tag carries a load queue index, so 16 entries at most
  localparam int TAG_W   = 4;

  typedef logic [2:0] size_t;

  // one op from rename; a not-ready operand holds its producer's rob id
  typedef struct packed {
    logic               is_store;
    size_t              size;
    logic [ROBID_W-1:0] robid;
    logic [RD_W-1:0]    rd;
    logic               op1ready;
    logic [XLEN-1:0]    op1;
    logic               op2ready;
    logic [XLEN-1:0]    op2;
    logic [XLEN-1:0]    imm;
  } lsq_disp_t;

  typedef struct packed {
    logic               valid;
    logic               error;
    logic [ROBID_W-1:0] robid;
    logic [RD_W-1:0]    rd;
    logic [XLEN-1:0]    result;
  } wb_bus_t;

  typedef struct packed {
    size_t size;
    logic  load;
  } dc_op_t;

  typedef struct packed {
    dc_op_t           op;
    logic [XLEN-1:0]  addr;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  wdata;
  } dc_req_t;

  typedef struct packed {
    logic             valid;
    logic             error;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  rdata;
  } dc_resp_t;

  typedef struct packed {
    logic               error;
    logic [ROBID_W-1:0] robid;
    logic [RD_W-1:0]    rd;
    logic [XLEN-1:0]    result;
  } lsq_result_t;

endpackage

`default_nettype wire

// File: design/lsq_addrgen.sv
// two-cycle base plus immediate address generator, one per queue, writes back by one-hot strobe
`timescale 1ns/1ps
`default_nettype none

module lsq_addrgen import lsq_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire  [DEPTH-1:0]            cand,
  input  wire  [DEPTH-1:0][XLEN-1:0]  base,
  input  wire  [DEPTH-1:0][XLEN-1:0]  imm,
  output logic [DEPTH-1:0]            wr_en,
  output logic [XLEN-1:0]             addr
);

  logic [DEPTH-1:0] cand_free;
  logic [DEPTH-1:0] pick;
  logic [DEPTH-1:0] sel;
  logic [XLEN-1:0]  sel_base;
  logic [XLEN-1:0]  sel_imm;

  // the entry in flight is not picked again
  assign cand_free = cand & ~sel;
  // isolate lowest set bit
  assign pick = cand_free & (~cand_free + DEPTH'(1));

  always_ff @(posedge clk) begin
    if (!rst) begin
      sel <= '0;
    end else begin
      sel <= pick;
    end
  end

  always_comb begin
    sel_base = '0;
    sel_imm  = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (sel[i]) begin
        sel_base = base[i];
        sel_imm  = imm[i];
      end
    end
  end

  assign addr  = sel_base + sel_imm;
  assign wr_en = sel;

endmodule

`default_nettype wire

// File: design/load_queue.sv
// load queue: holds loads from dispatch to writeback, issues to the dcache with tag = entry index
`timescale 1ns/1ps
`default_nettype none

module load_queue import lsq_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  wire               clk,
  input  wire               rst,
  input  wire               flush,
  input  wire               insert,
  input  wire  lsq_disp_t   disp,
  input  wire  wb_bus_t     wb_in,
  input  wire               conflict,
  input  wire               grant,
  input  wire  dc_resp_t    dc_resp,
  input  wire               wb_out_stall,
  output logic              full,
  output logic              req_valid,
  output dc_req_t           req,
  output logic [XLEN-1:0]   check_addr,
  output logic              wb_out_valid,
  output lsq_result_t       wb_out
);

  logic [DEPTH-1:0] valid, pend, base_rdy, addr_rdy, issued, complete, error;
  size_t [DEPTH-1:0]              size_r;
  logic  [DEPTH-1:0][ROBID_W-1:0] robid_r;
  logic  [DEPTH-1:0][RD_W-1:0]    rd_r;
  logic  [DEPTH-1:0][XLEN-1:0]    base, imm, addr, data;

  logic [DEPTH-1:0] free, ins_sel, ins_en, base_wake, ag_wr, resp_hit;
  logic [DEPTH-1:0] issuable, iss_sel, iss_en, done, wb_pick, wb_sel, wb_hold, remove;
  logic [XLEN-1:0]  ag_addr;
  logic [TAG_W-1:0] iss_tag;
  size_t            iss_size;
  logic             wb_en, wb_lock;

  // a flushed load still waiting on its response keeps its slot busy
  assign free    = ~(valid | pend);
  assign ins_sel = free & (~free + DEPTH'(1));
  assign ins_en  = ins_sel & {DEPTH{insert & ~flush}};
  assign full    = ~|free;
  assign wb_en   = wb_in.valid & ~wb_in.error;

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      base_wake[i] = wb_en & valid[i] & ~base_rdy[i] &
                     (base[i][ROBID_W-1:0] == wb_in.robid);
      resp_hit[i]  = dc_resp.valid & pend[i] & (dc_resp.tag == TAG_W'(i));
    end
  end

  lsq_addrgen #(.DEPTH(DEPTH)) addrgen (
    .clk   (clk),
    .rst   (rst),
    .cand  (valid & base_rdy & ~addr_rdy),
    .base  (base),
    .imm   (imm),
    .wr_en (ag_wr),
    .addr  (ag_addr)
  );

  // issue lowest index first
  assign issuable = valid & addr_rdy & ~issued;
  assign iss_sel  = issuable & (~issuable + DEPTH'(1));
  assign iss_en   = iss_sel & {DEPTH{grant}};

  always_comb begin
    check_addr = '0;
    iss_tag    = '0;
    iss_size   = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (iss_sel[i]) begin
        check_addr = addr[i];
        iss_tag    = TAG_W'(i);
        iss_size   = size_r[i];
      end
    end
  end

  assign req_valid    = (|iss_sel) & ~conflict;
  assign req.op.size  = iss_size;
  assign req.op.load  = 1'b1;
  assign req.addr     = check_addr;
  assign req.tag      = iss_tag;
  assign req.wdata    = '0;

  // writeback choice is frozen while the consumer stalls
  assign done         = valid & complete;
  assign wb_pick      = done & (~done + DEPTH'(1));
  assign wb_sel       = wb_lock ? wb_hold : wb_pick;
  assign wb_out_valid = |(wb_sel & done);
  assign remove       = wb_sel & {DEPTH{wb_out_valid & ~wb_out_stall}};

  always_comb begin
    wb_out = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (wb_sel[i]) begin
        wb_out.error  = error[i];
        wb_out.robid  = robid_r[i];
        wb_out.rd     = rd_r[i];
        wb_out.result = data[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst || flush) begin
      wb_lock <= 1'b0;
    end else begin
      wb_lock <= wb_out_valid & wb_out_stall;
    end
    wb_hold <= wb_sel;
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (!rst) begin
        valid[i]    <= 1'b0;
        pend[i]     <= 1'b0;
        base_rdy[i] <= 1'b0;
        addr_rdy[i] <= 1'b0;
        issued[i]   <= 1'b0;
        complete[i] <= 1'b0;
        error[i]    <= 1'b0;
      end else begin
        if (ins_en[i]) begin
          valid[i] <= 1'b1;
        end else if (flush || remove[i]) begin
          valid[i] <= 1'b0;
        end
        if (iss_en[i]) begin
          pend[i] <= 1'b1;
        end else if (resp_hit[i]) begin
          pend[i] <= 1'b0;
        end
        if (ins_en[i]) begin
          base_rdy[i] <= disp.op1ready;
          addr_rdy[i] <= 1'b0;
          issued[i]   <= 1'b0;
          complete[i] <= 1'b0;
        end else begin
          base_rdy[i] <= base_rdy[i] | base_wake[i];
          addr_rdy[i] <= addr_rdy[i] | ag_wr[i];
          issued[i]   <= issued[i] | iss_en[i];
          complete[i] <= complete[i] | (resp_hit[i] & valid[i]);
        end
        if (resp_hit[i] && valid[i]) begin
          error[i] <= dc_resp.error;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (ins_en[i]) begin
        size_r[i]  <= disp.size;
        robid_r[i] <= disp.robid;
        rd_r[i]    <= disp.rd;
        imm[i]     <= disp.imm;
        base[i]    <= disp.op1;
      end else if (base_wake[i]) begin
        base[i] <= wb_in.result;
      end
      if (ag_wr[i] && !ins_en[i]) begin
        addr[i] <= ag_addr;
      end
      if (resp_hit[i]) begin
        data[i] <= dc_resp.rdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/store_queue.sv
// store queue ring: stores enter at tail, retire at mid and issue in order from head
`timescale 1ns/1ps
`default_nettype none

module store_queue import lsq_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              flush,
  input  wire              insert,
  input  wire  lsq_disp_t  disp,
  input  wire  wb_bus_t    wb_in,
  input  wire              retire,
  input  wire  [XLEN-1:0]  check_addr,
  input  wire              grant,
  output logic             full,
  output logic             conflict,
  output logic             req_valid,
  output dc_req_t          req
);

  logic [DEPTH-1:0] valid, base_rdy, addr_rdy, data_rdy, retired;
  size_t [DEPTH-1:0]           size_r;
  logic  [DEPTH-1:0][XLEN-1:0] base, imm, addr, data;

  // one-hot ring pointers, polarity flips on wrap
  logic [DEPTH-1:0] head, mid, tail, mid_nxt;
  logic             head_pol, mid_pol, tail_pol, mid_pol_nxt;

  logic [DEPTH-1:0] ins_en, ret_en, iss_en, base_wake, data_wake, ag_wr, ready, hits;
  logic [XLEN-1:0]  ag_addr;
  logic [XLEN-1:0]  head_addr;
  logic [XLEN-1:0]  head_data;
  size_t            head_size;
  logic             wb_en;

  assign full   = (|(head & tail)) & (head_pol ^ tail_pol);
  assign ins_en = tail & {DEPTH{insert & ~flush}};
  assign ret_en = mid & {DEPTH{retire}};
  assign iss_en = head & {DEPTH{grant}};
  assign wb_en  = wb_in.valid & ~wb_in.error;

  assign mid_nxt     = retire ? {mid[DEPTH-2:0], mid[DEPTH-1]} : mid;
  assign mid_pol_nxt = mid_pol ^ (retire & mid[DEPTH-1]);

  always_ff @(posedge clk) begin
    if (!rst) begin
      head     <= DEPTH'(1);
      mid      <= DEPTH'(1);
      tail     <= DEPTH'(1);
      head_pol <= 1'b0;
      mid_pol  <= 1'b0;
      tail_pol <= 1'b0;
    end else begin
      if (grant) begin
        head     <= {head[DEPTH-2:0], head[DEPTH-1]};
        head_pol <= head_pol ^ head[DEPTH-1];
      end
      mid     <= mid_nxt;
      mid_pol <= mid_pol_nxt;
      // flush drops everything past the retired stores
      if (flush) begin
        tail     <= mid_nxt;
        tail_pol <= mid_pol_nxt;
      end else if (insert) begin
        tail     <= {tail[DEPTH-2:0], tail[DEPTH-1]};
        tail_pol <= tail_pol ^ tail[DEPTH-1];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      base_wake[i] = wb_en & valid[i] & ~base_rdy[i] &
                     (base[i][ROBID_W-1:0] == wb_in.robid);
      data_wake[i] = wb_en & valid[i] & ~data_rdy[i] &
                     (data[i][ROBID_W-1:0] == wb_in.robid);
      // unknown address counts as a hit
      hits[i] = valid[i] & (~addr_rdy[i] | (addr[i][XLEN-1:2] == check_addr[XLEN-1:2]));
    end
  end

  assign conflict = |hits;

  lsq_addrgen #(.DEPTH(DEPTH)) addrgen (
    .clk   (clk),
    .rst   (rst),
    .cand  (valid & base_rdy & ~addr_rdy),
    .base  (base),
    .imm   (imm),
    .wr_en (ag_wr),
    .addr  (ag_addr)
  );

  assign ready     = head & valid & addr_rdy & data_rdy & retired;
  assign req_valid = |ready;

  always_comb begin
    head_addr = '0;
    head_data = '0;
    head_size = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (head[i]) begin
        head_addr = addr[i];
        head_data = data[i];
        head_size = size_r[i];
      end
    end
  end

  assign req.op.size = head_size;
  assign req.op.load = 1'b0;
  assign req.addr    = head_addr;
  assign req.tag     = '0;
  assign req.wdata   = head_data;

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (!rst) begin
        valid[i]    <= 1'b0;
        base_rdy[i] <= 1'b0;
        addr_rdy[i] <= 1'b0;
        data_rdy[i] <= 1'b0;
        retired[i]  <= 1'b0;
      end else begin
        if (ins_en[i]) begin
          valid[i] <= 1'b1;
        end else if (iss_en[i] || (flush && !retired[i] && !ret_en[i])) begin
          valid[i] <= 1'b0;
        end
        if (ins_en[i]) begin
          base_rdy[i] <= disp.op1ready;
          data_rdy[i] <= disp.op2ready;
          addr_rdy[i] <= 1'b0;
          retired[i]  <= 1'b0;
        end else begin
          base_rdy[i] <= base_rdy[i] | base_wake[i];
          data_rdy[i] <= data_rdy[i] | data_wake[i];
          addr_rdy[i] <= addr_rdy[i] | ag_wr[i];
          retired[i]  <= retired[i] | ret_en[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (ins_en[i]) begin
        size_r[i] <= disp.size;
        imm[i]    <= disp.imm;
        base[i]   <= disp.op1;
        data[i]   <= disp.op2;
      end else begin
        if (base_wake[i]) begin
          base[i] <= wb_in.result;
        end
        if (data_wake[i]) begin
          data[i] <= wb_in.result;
        end
      end
      if (ag_wr[i] && !ins_en[i]) begin
        addr[i] <= ag_addr;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/lsq_issue_select.sv
// dcache port arbiter and dispatch steering between load and store queues
`timescale 1ns/1ps
`default_nettype none

module lsq_issue_select import lsq_pkg::*; (
  input  wire            disp_valid,
  input  wire            is_store,
  input  wire            ld_full,
  input  wire            st_full,
  input  wire            ld_valid,
  input  wire  dc_req_t  ld_req,
  input  wire            st_valid,
  input  wire  dc_req_t  st_req,
  input  wire            dc_ready,
  input  wire            flush,
  output logic           stall,
  output logic           ld_insert,
  output logic           st_insert,
  output logic           dc_req_valid,
  output dc_req_t        dc_req,
  output logic           ld_grant,
  output logic           st_grant
);

  logic ld_go;
  logic st_go;

  // stall follows the queue the op is headed for
  assign stall     = is_store ? st_full : ld_full;
  assign ld_insert = disp_valid & ~is_store & ~ld_full;
  assign st_insert = disp_valid & is_store & ~st_full;

  // loads win, nothing goes out during a flush
  assign ld_go = ld_valid & ~flush;
  assign st_go = st_valid & ~ld_valid & ~flush;

  assign dc_req_valid = ld_go | st_go;
  assign dc_req       = ld_valid ? ld_req : st_req;
  assign ld_grant     = ld_go & dc_ready;
  assign st_grant     = st_go & dc_ready;

endmodule

`default_nettype wire

// File: design/lsq.sv
// load-store queue top level, connects both queues and the dcache issue selector
`timescale 1ns/1ps
`default_nettype none

module lsq import lsq_pkg::*; #(
  parameter int LQ_DEPTH = 8,
  parameter int SQ_DEPTH = 8
) (
  input  wire                clk,
  input  wire                rst,
  input  wire                disp_valid,
  input  wire  lsq_disp_t    disp,
  output logic               stall,
  input  wire  wb_bus_t      wb_in,
  input  wire                rob_ret_store,
  input  wire                rob_flush,
  output logic               dc_req_valid,
  output dc_req_t            dc_req,
  input  wire                dc_ready,
  input  wire  dc_resp_t     dc_resp,
  output logic               wb_out_valid,
  output lsq_result_t        wb_out,
  input  wire                wb_out_stall
);

  logic            ld_full, st_full;
  logic            ld_insert, st_insert;
  logic            ld_req_valid, st_req_valid;
  logic            ld_grant, st_grant;
  dc_req_t         ld_req, st_req;
  logic [XLEN-1:0] check_addr;
  logic            conflict;

  load_queue #(.DEPTH(LQ_DEPTH)) lq (
    .clk          (clk),
    .rst          (rst),
    .flush        (rob_flush),
    .insert       (ld_insert),
    .disp         (disp),
    .wb_in        (wb_in),
    .conflict     (conflict),
    .grant        (ld_grant),
    .dc_resp      (dc_resp),
    .wb_out_stall (wb_out_stall),
    .full         (ld_full),
    .req_valid    (ld_req_valid),
    .req          (ld_req),
    .check_addr   (check_addr),
    .wb_out_valid (wb_out_valid),
    .wb_out       (wb_out)
  );

  store_queue #(.DEPTH(SQ_DEPTH)) sq (
    .clk        (clk),
    .rst        (rst),
    .flush      (rob_flush),
    .insert     (st_insert),
    .disp       (disp),
    .wb_in      (wb_in),
    .retire     (rob_ret_store),
    .check_addr (check_addr),
    .grant      (st_grant),
    .full       (st_full),
    .conflict   (conflict),
    .req_valid  (st_req_valid),
    .req        (st_req)
  );

  lsq_issue_select sel (
    .disp_valid   (disp_valid),
    .is_store     (disp.is_store),
    .ld_full      (ld_full),
    .st_full      (st_full),
    .ld_valid     (ld_req_valid),
    .ld_req       (ld_req),
    .st_valid     (st_req_valid),
    .st_req       (st_req),
    .dc_ready     (dc_ready),
    .flush        (rob_flush),
    .stall        (stall),
    .ld_insert    (ld_insert),
    .st_insert    (st_insert),
    .dc_req_valid (dc_req_valid),
    .dc_req       (dc_req),
    .ld_grant     (ld_grant),
    .st_grant     (st_grant)
  );

endmodule

`default_nettype wire

// File: bench/lsq_ref.svh
// reference memory model and expected-value functions, included inside the lsq testbench module
`ifndef LSQ_REF_SVH
`define LSQ_REF_SVH
`default_nettype none

  // word memory, keyed by word address
  logic [31:0] mem [logic [29:0]];

  // untouched words read back a pattern built from the full word address
  function automatic logic [31:0] fill_word(input logic [29:0] w);
    logic [31:0] v;
    v = {w, 2'b00};
    return v ^ {v[15:0], v[31:16]} ^ 32'h6b3c_19e5;
  endfunction

  // expected data of a load from addr
  function automatic logic [31:0] ref_load(input logic [31:0] addr);
    logic [29:0] w;
    w = addr[31:2];
    if (mem.exists(w)) begin
      return mem[w];
    end
    return fill_word(w);
  endfunction

  function automatic void mem_write(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[31:2]] = data;
  endfunction

  // effective address of a load or store
  function automatic logic [31:0] ref_addr(input logic [31:0] base, input logic [31:0] imm);
    return base + imm;
  endfunction

  // one dispatch word, word-sized access
  function automatic lsq_disp_t make_op(
    input logic        is_store,
    input logic [6:0]  robid,
    input logic [4:0]  rd,
    input logic        op1ready,
    input logic [31:0] op1,
    input logic        op2ready,
    input logic [31:0] op2,
    input logic [31:0] imm
  );
    lsq_disp_t d;
    d.is_store = is_store;
    d.size     = 3'b010;
    d.robid    = robid;
    d.rd       = rd;
    d.op1ready = op1ready;
    d.op1      = op1;
    d.op2ready = op2ready;
    d.op2      = op2;
    d.imm      = imm;
    return d;
  endfunction

`default_nettype wire
`endif

// File: bench/lsq_tb.sv
// self-checking testbench for the lsq top level with a randomized dcache responder
`timescale 1ns/1ps
`default_nettype none

module lsq_tb import lsq_pkg::*;;

  localparam int N_OPS = 22;

  typedef struct packed {
    logic [3:0]  tag;
    logic        err;
    logic [31:0] data;
    logic [7:0]  wait_cnt;
  } pend_resp_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        disp_valid;
  lsq_disp_t   disp;
  logic        stall;
  wb_bus_t     wb_in;
  logic        rob_ret_store;
  logic        rob_flush;
  logic        dc_req_valid;
  dc_req_t     dc_req;
  logic        dc_ready = 1'b0;
  dc_resp_t    dc_resp = '0;
  logic        wb_out_valid;
  lsq_result_t wb_out;
  logic        wb_out_stall = 1'b0;

  lsq_result_t exp_wb[$];
  dc_req_t     exp_st[$];
  pend_resp_t  pend_q[$];
  string       cur_test = "reset";
  logic [31:0] err_addr = 32'hffff_fff0;

  `include "lsq_ref.svh"

  lsq #(.LQ_DEPTH(8), .SQ_DEPTH(8)) uut (
    .clk           (clk),
    .rst           (rst),
    .disp_valid    (disp_valid),
    .disp          (disp),
    .stall         (stall),
    .wb_in         (wb_in),
    .rob_ret_store (rob_ret_store),
    .rob_flush     (rob_flush),
    .dc_req_valid  (dc_req_valid),
    .dc_req        (dc_req),
    .dc_ready      (dc_ready),
    .dc_resp       (dc_resp),
    .wb_out_valid  (wb_out_valid),
    .wb_out        (wb_out),
    .wb_out_stall  (wb_out_stall)
  );

  always #2 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic compare_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      report_failure($sformatf("mismatch %s %s expected %h actual %h", cur_test, what, exp, act));
    end
  endtask

  // random back-pressure on both sides
  always @(posedge clk) begin
    dc_ready     <= ($urandom % 4) != 0;
    wb_out_stall <= ($urandom % 4) == 0;
  end

  // dcache model that answers loads out of order after a random delay
  always @(posedge clk) begin : responder
    int pick;
    dc_resp_t r;
    pend_resp_t p;
    pick = -1;
    r = '0;
    for (int i = 0; i < pend_q.size(); i++) begin
      if (pend_q[i].wait_cnt == 0 && pick < 0) begin
        pick = i;
      end else if (pend_q[i].wait_cnt != 0) begin
        pend_q[i].wait_cnt = pend_q[i].wait_cnt - 8'd1;
      end
    end
    if (pick >= 0) begin
      r.valid = 1'b1;
      r.error = pend_q[pick].err;
      r.tag   = pend_q[pick].tag;
      r.rdata = pend_q[pick].data;
      pend_q.delete(pick);
    end
    if (rst && dc_req_valid && dc_ready) begin
      if (dc_req.op.load) begin
        p.tag      = dc_req.tag;
        p.err      = dc_req.addr[31:2] == err_addr[31:2];
        p.data     = ref_load(dc_req.addr);
        p.wait_cnt = 8'($urandom % 6);
        pend_q.push_back(p);
      end else begin
        mem_write(dc_req.addr, dc_req.wdata);
      end
    end
    dc_resp <= r;
  end

  // checks every writeback and store beat against the expected queues
  always @(posedge clk) begin : compare
    int k;
    dc_req_t s;
    if (rst && wb_out_valid && !wb_out_stall) begin
      k = -1;
      for (int i = 0; i < exp_wb.size(); i++) begin
        if (exp_wb[i].robid == wb_out.robid && k < 0) begin
          k = i;
        end
      end
      assert (k >= 0) else begin
        report_failure($sformatf("unexpected writeback for robid %0d in %s",
                                 wb_out.robid, cur_test));
      end
      compare_value("rd", 32'(exp_wb[k].rd), 32'(wb_out.rd));
      compare_value("error", 32'(exp_wb[k].error), 32'(wb_out.error));
      if (!exp_wb[k].error) begin
        compare_value("load data", exp_wb[k].result, wb_out.result);
      end
      exp_wb.delete(k);
    end
    if (rst && dc_req_valid && dc_ready && !dc_req.op.load) begin
      assert (exp_st.size() != 0) else begin
        report_failure($sformatf("unexpected store beat at %h in %s", dc_req.addr, cur_test));
      end
      s = exp_st.pop_front();
      compare_value("store addr", s.addr, dc_req.addr);
      compare_value("store data", s.wdata, dc_req.wdata);
    end
  end

  task automatic dispatch(input lsq_disp_t d);
    @(posedge clk);
    disp_valid <= 1'b1;
    disp       <= d;
    do begin
      @(posedge clk);
    end while (stall);
    disp_valid <= 1'b0;
  endtask

  task automatic retire_store();
    @(posedge clk);
    rob_ret_store <= 1'b1;
    @(posedge clk);
    rob_ret_store <= 1'b0;
  endtask

  task automatic broadcast(input logic [6:0] robid, input logic [31:0] result);
    @(posedge clk);
    wb_in <= '{valid: 1'b1, error: 1'b0, robid: robid, rd: 5'd0, result: result};
    @(posedge clk);
    wb_in <= '0;
  endtask

  task automatic expect_load(input logic [6:0] robid, input logic [4:0] rd,
                             input logic err, input logic [31:0] data);
    exp_wb.push_back('{error: err, robid: robid, rd: rd, result: data});
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    dc_req_t s;
    s = '0;
    s.addr  = addr;
    s.wdata = data;
    exp_st.push_back(s);
  endtask

  task automatic drain();
    while (exp_wb.size() != 0 || exp_st.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);
  endtask

  initial begin : watchdog
    repeat (N_OPS * 200) @(posedge clk);
    report_failure("timeout, the queues did not drain in time");
  end

  initial begin
    void'($urandom(23896));
    rst           = 1'b0;
    disp_valid    = 1'b0;
    disp          = '0;
    wb_in         = '0;
    rob_ret_store = 1'b0;
    rob_flush     = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b1;

    cur_test = "load_writeback";
    for (int i = 0; i < 3; i++) begin
      expect_load(7'(1 + i), 5'(3 + i), 1'b0, ref_load(ref_addr(32'h1000 + 32'(i * 16), 32'h8)));
      dispatch(make_op(1'b0, 7'(1 + i), 5'(3 + i), 1'b1, 32'h1000 + 32'(i * 16),
                       1'b1, 32'h0, 32'h8));
    end
    drain();

    cur_test = "store_order";
    for (int i = 0; i < 3; i++) begin
      dispatch(make_op(1'b1, 7'(10 + i), 5'd0, 1'b1, 32'h2000 + 32'(i * 4),
                       1'b1, 32'hc0de_0000 + 32'(i), 32'h10));
    end
    repeat (10) @(posedge clk);
    // a store may reach the dcache only once it has retired
    for (int i = 0; i < 3; i++) begin
      expect_store(ref_addr(32'h2000 + 32'(i * 4), 32'h10), 32'hc0de_0000 + 32'(i));
      retire_store();
    end
    drain();

    cur_test = "operand_wakeup";
    dispatch(make_op(1'b1, 7'h20, 5'd0, 1'b1, 32'h2800, 1'b0, 32'h22, 32'h4));
    dispatch(make_op(1'b0, 7'h23, 5'd7, 1'b0, 32'h21, 1'b1, 32'h0, 32'h24));
    expect_store(ref_addr(32'h2800, 32'h4), 32'h5151_a0a0);
    expect_load(7'h23, 5'd7, 1'b0, ref_load(ref_addr(32'h1800, 32'h24)));
    broadcast(7'h21, 32'h1800);
    broadcast(7'h22, 32'h5151_a0a0);
    retire_store();
    drain();

    cur_test = "load_after_store";
    // the load sits behind the unretired store to the same word
    dispatch(make_op(1'b1, 7'h30, 5'd0, 1'b1, 32'h3000, 1'b1, 32'hfeed_beef, 32'h0));
    dispatch(make_op(1'b0, 7'h31, 5'd9, 1'b1, 32'h2ff0, 1'b1, 32'h0, 32'h10));
    expect_store(32'h3000, 32'hfeed_beef);
    expect_load(7'h31, 5'd9, 1'b0, 32'hfeed_beef);
    retire_store();
    drain();

    cur_test = "error_response";
    err_addr = 32'h4000;
    expect_load(7'h40, 5'd11, 1'b1, 32'h0);
    dispatch(make_op(1'b0, 7'h40, 5'd11, 1'b1, 32'h3ffc, 1'b1, 32'h0, 32'h4));
    drain();

    cur_test = "flush";
    expect_store(32'h5000, 32'h0bad_cafe);
    dispatch(make_op(1'b1, 7'h50, 5'd0, 1'b1, 32'h5000, 1'b1, 32'h0bad_cafe, 32'h0));
    dispatch(make_op(1'b1, 7'h51, 5'd0, 1'b0, 32'h52, 1'b1, 32'h1111_2222, 32'h0));
    dispatch(make_op(1'b0, 7'h53, 5'd12, 1'b0, 32'h54, 1'b1, 32'h0, 32'h0));
    // oldest store retires in the flush cycle and has not issued yet
    @(posedge clk);
    rob_ret_store <= 1'b1;
    rob_flush     <= 1'b1;
    @(posedge clk);
    rob_ret_store <= 1'b0;
    rob_flush     <= 1'b0;
    broadcast(7'h52, 32'h5100);
    broadcast(7'h54, 32'h5200);
    drain();

    cur_test = "queue_full";
    for (int i = 0; i < 8; i++) begin
      dispatch(make_op(1'b1, 7'(96 + i), 5'd0, 1'b0, 32'(112 + i), 1'b1, 32'h0, 32'h0));
    end
    @(posedge clk);
    compare_value("stall", 32'd1, 32'(stall));
    disp <= make_op(1'b0, 7'h78, 5'd1, 1'b1, 32'h6000, 1'b1, 32'h0, 32'h0);
    @(posedge clk);
    compare_value("stall", 32'd0, 32'(stall));
    disp      <= make_op(1'b1, 7'h79, 5'd0, 1'b1, 32'h6000, 1'b1, 32'h0, 32'h0);
    rob_flush <= 1'b1;
    @(posedge clk);
    rob_flush <= 1'b0;
    @(posedge clk);
    compare_value("stall", 32'd0, 32'(stall));
    drain();
    repeat (40) @(posedge clk);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+bench
design/lsq_pkg.sv
design/lsq_addrgen.sv
design/load_queue.sv
design/store_queue.sv
design/lsq_issue_select.sv
design/lsq.sv
bench/lsq_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the lsq testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module lsq_tb -f compile.f -o lsq_sim \
  && ./obj_dir/lsq_sim | tee /dev/stderr | grep -qF ">>> PASS" \
  && echo "simulation finished without errors" \
  || { echo "simulation failed"; exit 1; }
